/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = nabp_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# pass only if the pass message shows up in the simulation output
run: compile
	./$(SIM) | tee /dev/stderr | grep -F -- '** PASS **' > /dev/null

clean:
	rm -rf $(OBJ_DIR)

/* bench/nabp_tb.sv */
`timescale 1ns/1ps

module nabp_tb;
    import nabp_pkg::*;

    localparam int IMAGE_SIZE = 16;
    localparam int NUM_PES = 4;
    localparam int TAP_SPACING = 3;
    localparam int DEPTH = (NUM_PES - 1) * TAP_SPACING + 1;
    localparam int ADDR_W = angle_w + $clog2(IMAGE_SIZE);
    localparam int MAX_ANGLES = 6;
    // six runs in total over all tests
    localparam int NUM_RUNS = 6;
    localparam int TIMEOUT = NUM_RUNS * MAX_ANGLES * (DEPTH + IMAGE_SIZE + 8) + 200;

    logic clk = 1'b0;
    logic reset_n;
    logic start;
    logic [angle_w-1:0] num_angles;
    shift_accu_t accu_base;
    sample_t ram_data = '0;
    logic [ADDR_W-1:0] ram_addr;
    logic busy;
    logic done;
    logic [NUM_PES-1:0][sum_w-1:0] pe_sums;

    logic [31:0] lcg_state = 32'd40771;
    int cycle_cnt = 0;
    int done_cnt = 0;
    int run_angles = 0;
    int last_row = 0;

    nabp_top #(.IMAGE_SIZE(IMAGE_SIZE), .NUM_PES(NUM_PES), .TAP_SPACING(TAP_SPACING)) UUT (
        .clk(clk), .reset_n(reset_n), .start(start), .num_angles(num_angles),
        .accu_base(accu_base), .ram_data(ram_data), .ram_addr(ram_addr),
        .busy(busy), .done(done), .pe_sums(pe_sums)
    );

    always #10 clk = ~clk;

    // projection RAM contents, one word per address
    function automatic sample_t ram_word(input int addr);
        return sample_t'(addr * 7 + 3);
    endfunction

    // synchronous read, one cycle latency
    always @(posedge clk)
    begin
        ram_data <= ram_word(int'(ram_addr));
    end

    function automatic int rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[30:16]);
    endfunction

    // odd raw value, so the fraction is never zero
    function automatic logic [accu_w-1:0] random_base();
        return accu_w'((16 + rand_next() % 496) | 1);
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            fail_now($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT)
            fail_now("timeout: the DUT did not finish its runs in time");
    end

    // done pulses and row of every address issued during a run
    always @(negedge clk)
    begin
        int row;
        if (reset_n)
        begin
            if (done)
                done_cnt++;
            if (busy)
            begin
                row = int'(ram_addr) / IMAGE_SIZE;
                if (row >= run_angles || row < last_row || row > last_row + 1)
                    fail_now($sformatf("ram_addr 0x%0h left the expected angle row", ram_addr));
                last_row = row;
            end
        end
    end

    // expected sums: clear, fill depth columns, then step the accumulator
    task automatic model_sums(input int angles, input logic [accu_w-1:0] base,
                              output logic [NUM_PES-1:0][sum_w-1:0] sums);
        logic [DEPTH-1:0][sample_w-1:0] line;
        logic [accu_w-1:0] accu;
        logic [accu_w-1:0] accu_nxt;
        logic do_shift;
        int col;
        sums = '0;
        for (int a = 0; a < angles; a++)
        begin
            line = '0;
            accu = '0;
            col = 0;
            for (int s = 0; s < DEPTH + IMAGE_SIZE; s++)
            begin
                do_shift = 1'b1;
                if (s >= DEPTH)
                begin
                    accu_nxt = accu + base;
                    do_shift = accu_nxt[accu_w-1:accu_frac_w] != accu[accu_w-1:accu_frac_w];
                    accu = accu_nxt;
                end
                if (do_shift)
                begin
                    line = {line[DEPTH-2:0], ram_word(a * IMAGE_SIZE + col)};
                    if (col < IMAGE_SIZE - 1)
                        col++;
                end
                if (s >= DEPTH)
                begin
                    for (int k = 0; k < NUM_PES; k++)
                        sums[k] = sums[k] + sum_w'($signed(line[k * TAP_SPACING]));
                end
            end
        end
    endtask

    task automatic run_and_check(input int angles, input logic [accu_w-1:0] base,
                                 input bit poke_busy);
        logic [NUM_PES-1:0][sum_w-1:0] expected;
        model_sums(angles, base, expected);
        run_angles = angles;
        last_row = 0;
        done_cnt = 0;
        num_angles = angle_w'(angles);
        accu_base.raw = base;
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        if (poke_busy)
        begin
            repeat (6) @(posedge clk);
            #2;
            // other count and base, the run must not notice
            num_angles = angle_w'(angles + 3);
            accu_base.raw = ~base;
            start = 1'b1;
            @(posedge clk);
            #2;
            start = 1'b0;
        end
        while (!done)
            @(negedge clk);
        for (int k = 0; k < NUM_PES; k++)
            check_value($sformatf("pe_sums[%0d]", k), 32'(pe_sums[k]), 32'(expected[k]));
        check_value("last ram_addr row", 32'(last_row), 32'(angles - 1));
        repeat (4) @(posedge clk);
        #2;
        check_value("done pulse count", 32'(done_cnt), 32'd1);
        check_value("busy", 32'(busy), 32'd0);
    endtask

    task automatic check_reset_values();
        check_value("busy", 32'(busy), 32'd0);
        check_value("done", 32'(done), 32'd0);
        for (int k = 0; k < NUM_PES; k++)
            check_value($sformatf("pe_sums[%0d]", k), 32'(pe_sums[k]), 32'd0);
    endtask

    task automatic run_random_angles();
        for (int r = 0; r < 2; r++)
            run_and_check(2 + rand_next() % (MAX_ANGLES - 1), random_base(), 1'b1);
    endtask

    task automatic restart_after_done();
        run_and_check(2 + rand_next() % (MAX_ANGLES - 1), random_base(), 1'b0);
        // old sums must be gone
        run_and_check(1 + rand_next() % MAX_ANGLES, random_base(), 1'b0);
    endtask

    initial
    begin
        reset_n = 1'b0;
        start = 1'b0;
        num_angles = '0;
        accu_base.raw = '0;
        repeat (16) @(posedge clk);
        #2;
        reset_n = 1'b1;
        check_reset_values();
        // base 1.0 and base 0.25
        run_and_check(1, 12'h100, 1'b0);
        run_and_check(1, 12'h040, 1'b0);
        run_random_angles();
        restart_after_done();
        $display("** PASS **");
        $finish;
    end

endmodule

/* flist.f */
src/nabp_pkg.sv
src/nabp_state_control.sv
src/nabp_shifter.sv
src/nabp_filter_mapper.sv
src/nabp_line_buffer.sv
src/nabp_pe_array.sv
src/nabp_top.sv
bench/nabp_tb.sv

/* src/nabp_filter_mapper.sv */
`timescale 1ns/1ps

module nabp_filter_mapper #(
    parameter int IMAGE_SIZE = 16
) (
    input  logic clk,
    input  logic reset_n,
    input  logic mp_kick,
    input  nabp_pkg::shifter_ctrl_t ctrl,
    input  logic [nabp_pkg::angle_w-1:0] angle,
    input  nabp_pkg::sample_t ram_data,
    output logic [nabp_pkg::angle_w+$clog2(IMAGE_SIZE)-1:0] ram_addr,
    output nabp_pkg::sample_t sample
);
    import nabp_pkg::*;

    localparam int COL_W = $clog2(IMAGE_SIZE);
    localparam int ADDR_W = angle_w + COL_W;

    logic [COL_W-1:0] col;
    logic [COL_W-1:0] col_nxt;

    // column saturates at the last pixel of the row
    always_comb
    begin
        col_nxt = col;
        if (mp_kick)
            col_nxt = '0;
        else if (ctrl.mp_shift_en && (col != COL_W'(IMAGE_SIZE - 1)))
            col_nxt = col + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            col <= '0;
        else
            col <= col_nxt;
    end

    // address leads the counter by one cycle to hide the RAM latency,
    // so the word for the current column is registered when it shifts
    assign ram_addr = ADDR_W'(angle) * ADDR_W'(IMAGE_SIZE) + ADDR_W'(col_nxt);

    always_ff @(posedge clk)
    begin
        sample <= ram_data;
    end

endmodule

/* src/nabp_line_buffer.sv */
`timescale 1ns/1ps

module nabp_line_buffer #(
    parameter int NUM_PES = 4,
    parameter int TAP_SPACING = 3
) (
    input  logic clk,
    input  logic reset_n,
    input  nabp_pkg::shifter_ctrl_t ctrl,
    input  nabp_pkg::sample_t sample,
    output nabp_pkg::sample_t [NUM_PES-1:0] taps
);
    import nabp_pkg::*;

    localparam int DEPTH = (NUM_PES - 1) * TAP_SPACING + 1;

    sample_t [DEPTH-1:0] line_q;

    // new sample enters at entry 0, oldest falls off the top
    always_ff @(posedge clk)
    begin
        if (!reset_n || ctrl.lb_clear)
        begin
            line_q <= '0;
        end
        else if (ctrl.lb_shift_en)
        begin
            line_q <= {line_q[DEPTH-2:0], sample};
        end
    end

    // PE k watches entry k*TAP_SPACING
    genvar k;
    generate
        for (k = 0; k < NUM_PES; k++)
        begin : g_tap
            assign taps[k] = line_q[k * TAP_SPACING];
        end
    endgenerate

endmodule

/* src/nabp_pe_array.sv */
`timescale 1ns/1ps

module nabp_pe_array #(
    parameter int NUM_PES = 4
) (
    input  logic clk,
    input  logic reset_n,
    input  logic start,
    input  logic busy,
    input  nabp_pkg::shifter_ctrl_t ctrl,
    input  nabp_pkg::sample_t [NUM_PES-1:0] taps,
    output logic [NUM_PES-1:0][nabp_pkg::sum_w-1:0] pe_sums
);
    import nabp_pkg::*;

    genvar k;
    generate
        for (k = 0; k < NUM_PES; k++)
        begin : g_pe
            logic [sum_w-1:0] tap_ext;

            // taps are signed filtered samples
            assign tap_ext = {{(sum_w - sample_w){taps[k][sample_w-1]}}, taps[k]};

            always_ff @(posedge clk)
            begin
                if (!reset_n)
                    pe_sums[k] <= '0;
                else if (start && !busy)
                    pe_sums[k] <= '0;
                else if (ctrl.pe_en)
                    pe_sums[k] <= pe_sums[k] + tap_ext;
            end
        end
    endgenerate

    // accumulation only happens inside a run
    assert property (@(posedge clk) disable iff (!reset_n) ctrl.pe_en |-> busy);

endmodule

/* src/nabp_pkg.sv */
package nabp_pkg;

    // datapath widths
    localparam int sample_w = 12;
    localparam int sum_w = 24;

    // shift accumulator split, integer part on top
    localparam int accu_int_w = 4;
    localparam int accu_frac_w = 8;
    localparam int accu_w = accu_int_w + accu_frac_w;

    // angle index and angle count
    localparam int angle_w = 6;

    typedef logic [sample_w-1:0] sample_t;

    // raw view for the adder, fixed-point view for boundary detection
    typedef union packed {
        logic [accu_w-1:0] raw;
        struct packed {
            logic [accu_int_w-1:0] int_part;
            logic [accu_frac_w-1:0] frac_part;
        } fixed;
    } shift_accu_t;

    // shifter strobes to buffer, mapper and PEs
    typedef struct packed {
        logic lb_clear;
        // one cycle behind mp_shift_en
        logic lb_shift_en;
        // two cycles behind the shift state
        logic pe_en;
        logic mp_shift_en;
    } shifter_ctrl_t;

endpackage

/* src/nabp_shifter.sv */
`timescale 1ns/1ps

module nabp_shifter #(
    parameter int IMAGE_SIZE = 16,
    parameter int NUM_PES = 4,
    parameter int TAP_SPACING = 3
) (
    input  logic clk,
    input  logic reset_n,
    input  logic fill_kick,
    input  logic shift_kick,
    input  nabp_pkg::shift_accu_t accu_base,
    output logic fill_done,
    output logic shift_done,
    output logic mp_kick,
    output nabp_pkg::shifter_ctrl_t ctrl
);
    import nabp_pkg::*;

    localparam int DEPTH = (NUM_PES - 1) * TAP_SPACING + 1;
    localparam int CNT_W = $clog2(IMAGE_SIZE);

    localparam logic [1:0] S_READY = 2'd0;
    localparam logic [1:0] S_FILL = 2'd1;
    localparam logic [1:0] S_FILL_DONE = 2'd2;
    localparam logic [1:0] S_SHIFT = 2'd3;

    logic [1:0] state;
    logic [1:0] next_state;
    logic [CNT_W-1:0] cnt;
    shift_accu_t accu;
    shift_accu_t accu_next;
    logic fill_last;
    logic shift_last;
    logic mp_shift_en;
    logic lb_shift_q;
    logic [1:0] pe_en_pipe;
    logic [1:0] fill_done_pipe;
    logic [1:0] shift_done_pipe;

    // accumulator wraps freely, only integer crossings matter
    assign accu_next.raw = accu.raw + accu_base.raw;

    assign fill_last = (state == S_FILL) && (cnt == '0);
    assign shift_last = (state == S_SHIFT) && (cnt == '0);

    // every fill cycle, or a shift cycle crossing an integer boundary
    assign mp_shift_en = (state == S_FILL) ||
                         ((state == S_SHIFT) &&
                          (accu_next.fixed.int_part != accu.fixed.int_part));

    always_comb
    begin
        next_state = state;
        case (state)
            S_READY:
                if (fill_kick)
                    next_state = S_FILL;
            S_FILL:
                if (fill_last)
                    next_state = S_FILL_DONE;
            S_FILL_DONE:
                if (shift_kick)
                    next_state = S_SHIFT;
            default:
                if (shift_last)
                    next_state = S_READY;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= S_READY;
            cnt <= '0;
            accu.raw <= '0;
        end
        else
        begin
            state <= next_state;
            case (state)
                S_FILL, S_SHIFT:
                begin
                    if (cnt != '0)
                        cnt <= cnt - 1'b1;
                    if (state == S_SHIFT)
                        accu <= accu_next;
                end
                S_FILL_DONE:
                begin
                    cnt <= CNT_W'(IMAGE_SIZE - 1);
                    accu.raw <= '0;
                end
                default:
                begin
                    cnt <= CNT_W'(DEPTH - 1);
                    accu.raw <= '0;
                end
            endcase
        end
    end

    // one cycle for the RAM read, one more for the buffer taps
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            lb_shift_q <= 1'b0;
            pe_en_pipe <= '0;
            fill_done_pipe <= '0;
            shift_done_pipe <= '0;
        end
        else
        begin
            lb_shift_q <= mp_shift_en;
            pe_en_pipe <= {pe_en_pipe[0], state == S_SHIFT};
            fill_done_pipe <= {fill_done_pipe[0], fill_last};
            shift_done_pipe <= {shift_done_pipe[0], shift_last};
        end
    end

    assign fill_done = fill_done_pipe[1];
    assign shift_done = shift_done_pipe[1];
    assign mp_kick = fill_kick;

    always_comb
    begin
        ctrl.lb_clear = fill_kick;
        ctrl.lb_shift_en = lb_shift_q;
        ctrl.pe_en = pe_en_pipe[1];
        ctrl.mp_shift_en = mp_shift_en;
    end

    assert property (@(posedge clk) disable iff (!reset_n) shift_kick |-> state == S_FILL_DONE);

endmodule

/* src/nabp_state_control.sv */
`timescale 1ns/1ps

module nabp_state_control (
    input  logic clk,
    input  logic reset_n,
    input  logic start,
    input  logic [nabp_pkg::angle_w-1:0] num_angles,
    input  nabp_pkg::shift_accu_t accu_base_in,
    input  logic fill_done,
    input  logic shift_done,
    output logic fill_kick,
    output logic shift_kick,
    output nabp_pkg::shift_accu_t accu_base,
    output logic [nabp_pkg::angle_w-1:0] angle,
    output logic busy,
    output logic done
);
    import nabp_pkg::*;

    logic [angle_w-1:0] num_q;

    // one fill and one shift phase per angle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            fill_kick <= 1'b0;
            shift_kick <= 1'b0;
            angle <= '0;
            num_q <= '0;
            busy <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            fill_kick <= 1'b0;
            shift_kick <= 1'b0;
            done <= 1'b0;
            if (start && !busy)
            begin
                num_q <= num_angles;
                angle <= '0;
                // an empty run finishes at once
                if (num_angles == '0)
                begin
                    done <= 1'b1;
                end
                else
                begin
                    busy <= 1'b1;
                    fill_kick <= 1'b1;
                end
            end
            else if (busy && fill_done)
            begin
                shift_kick <= 1'b1;
            end
            else if (busy && shift_done)
            begin
                if (angle == num_q - 1'b1)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
                else
                begin
                    angle <= angle + 1'b1;
                    fill_kick <= 1'b1;
                end
            end
        end
    end

    // base is held for the whole run
    always_ff @(posedge clk)
    begin
        if (start && !busy)
        begin
            accu_base <= accu_base_in;
        end
    end

    // done pulses from the shifter never coincide
    assert property (@(posedge clk) disable iff (!reset_n) !(fill_done && shift_done));

endmodule

/* src/nabp_top.sv */
`timescale 1ns/1ps

module nabp_top #(
    parameter int IMAGE_SIZE = 16,
    parameter int NUM_PES = 4,
    parameter int TAP_SPACING = 3
) (
    input  logic clk,
    input  logic reset_n,
    input  logic start,
    input  logic [nabp_pkg::angle_w-1:0] num_angles,
    input  nabp_pkg::shift_accu_t accu_base,
    input  nabp_pkg::sample_t ram_data,
    output logic [nabp_pkg::angle_w+$clog2(IMAGE_SIZE)-1:0] ram_addr,
    output logic busy,
    output logic done,
    output logic [NUM_PES-1:0][nabp_pkg::sum_w-1:0] pe_sums
);
    import nabp_pkg::*;

    logic fill_kick;
    logic shift_kick;
    logic fill_done;
    logic shift_done;
    logic mp_kick;
    logic [angle_w-1:0] angle;
    shift_accu_t run_base;
    shifter_ctrl_t ctrl;
    sample_t sample;
    sample_t [NUM_PES-1:0] taps;

    nabp_state_control u_state_control (
        .clk(clk), .reset_n(reset_n), .start(start), .num_angles(num_angles),
        .accu_base_in(accu_base), .fill_done(fill_done), .shift_done(shift_done),
        .fill_kick(fill_kick), .shift_kick(shift_kick), .accu_base(run_base),
        .angle(angle), .busy(busy), .done(done)
    );

    nabp_shifter #(.IMAGE_SIZE(IMAGE_SIZE), .NUM_PES(NUM_PES), .TAP_SPACING(TAP_SPACING))
    u_shifter (
        .clk(clk), .reset_n(reset_n), .fill_kick(fill_kick), .shift_kick(shift_kick),
        .accu_base(run_base), .fill_done(fill_done), .shift_done(shift_done),
        .mp_kick(mp_kick), .ctrl(ctrl)
    );

    nabp_filter_mapper #(.IMAGE_SIZE(IMAGE_SIZE)) u_filter_mapper (
        .clk(clk), .reset_n(reset_n), .mp_kick(mp_kick), .ctrl(ctrl), .angle(angle),
        .ram_data(ram_data), .ram_addr(ram_addr), .sample(sample)
    );

    nabp_line_buffer #(.NUM_PES(NUM_PES), .TAP_SPACING(TAP_SPACING)) u_line_buffer (
        .clk(clk), .reset_n(reset_n), .ctrl(ctrl), .sample(sample), .taps(taps)
    );

    nabp_pe_array #(.NUM_PES(NUM_PES)) u_pe_array (
        .clk(clk), .reset_n(reset_n), .start(start), .busy(busy), .ctrl(ctrl),
        .taps(taps), .pe_sums(pe_sums)
    );

endmodule
